/* files.f */
verilog/rv_pkg.sv
verilog/rv_alu.sv
verilog/rv_execute.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_pipeline.sv
tb/tb_rv_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_pipeline
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

# Build and run, then decide the result from the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/rv_stimulus.txt */
// Columns, all hex: instruction, trap, write enable, rd, data
// Every line is one retired instruction, in program order
00500093 0 1 01 00000005  // addi x1, x0, 5
ffd00113 0 1 02 fffffffd  // addi x2, x0, -3
002081b3 0 1 03 00000002  // add  x3, x1, x2
40208233 0 1 04 00000008  // sub  x4, x1, x2
001122b3 0 1 05 00000001  // slt  x5, x2, x1
00113333 0 1 06 00000000  // sltu x6, x2, x1
0020c3b3 0 1 07 fffffff8  // xor  x7, x1, x2
0020e433 0 1 08 fffffffd  // or   x8, x1, x2
0020f4b3 0 1 09 00000005  // and  x9, x1, x2
00111533 0 1 0a ffffffa0  // sll  x10, x2, x1
001155b3 0 1 0b 07ffffff  // srl  x11, x2, x1
40115633 0 1 0c ffffffff  // sra  x12, x2, x1
ffe12693 0 1 0d 00000001  // slti  x13, x2, -2
fff0b713 0 1 0e 00000001  // sltiu x14, x1, -1
40115793 0 1 0f fffffffe  // srai  x15, x2, 1
00415813 0 1 10 0fffffff  // srli  x16, x2, 4
01f09893 0 1 11 80000000  // slli  x17, x1, 31
80000937 0 1 12 80000000  // lui  x18, 0x80000
001929b3 0 1 13 00000001  // slt  x19, x18, x1
00193a33 0 1 14 00000000  // sltu x20, x18, x1
12345ab7 0 1 15 12345000  // lui  x21, 0x12345
678a8a93 0 1 15 12345678  // addi x21, x21, 0x678
fffa8b13 0 1 16 12345677  // addi x22, x21, -1
016a8bb3 0 1 17 2468acef  // add  x23, x21, x22
00000a8b 1 0 15 00000000  // unknown opcode, rd x21
02108b33 1 0 16 00000000  // op_reg with funct7 0x01, rd x22
40109b93 1 0 17 00000000  // slli with funct7 0x20, rd x23
016a8c33 0 1 18 2468acef  // add  x24, x21, x22
000becb3 0 1 19 2468acef  // or   x25, x23, x0
00708013 0 0 00 0000000c  // addi x0, x1, 7
00100d33 0 1 1a 00000005  // add  x26, x0, x1
00008db3 0 1 1b 00000005  // add  x27, x1, x0

/* tb/tb_rv_pipeline.sv */
module tb_rv_pipeline;

  localparam int MAX_ENTRIES  = 64;
  localparam int FIELDS       = 5;
  localparam int PASSES       = 2;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int LEAD_IDLE    = 3;
  localparam int DRAIN_IDLE   = 8;

  logic              clk;
  logic              i_rst;
  logic              i_instr_valid;
  logic [31:0]       i_instr;
  logic              o_wb_valid;
  logic              o_wb_trap;
  logic              o_wb_we;
  rv_pkg::reg_addr_t o_wb_rd;
  rv_pkg::word_t     o_wb_data;

  // Entry k holds instr, trap, we, rd and data at words 5k to 5k+4
  logic [31:0] stim_mem [0:MAX_ENTRIES*FIELDS-1];
  int          num_entries;
  int          accepted;
  int          retired;
  logic [31:0] lcg_state;

  rv_pipeline u_dut (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .o_wb_valid    (o_wb_valid),
    .o_wb_trap     (o_wb_trap),
    .o_wb_we       (o_wb_we),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(string msg);
    $display("Error: %s", msg);
    stop_with_failure();
  endtask

  task automatic check_word(string name, rv_pkg::word_t exp, rv_pkg::word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_reg(string name, rv_pkg::reg_addr_t exp, rv_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic load_stimulus();
    int count;
    count = 0;
    for (int i = 0; i < MAX_ENTRIES * FIELDS; i++) begin
      stim_mem[i] = 32'hee00_0000 | 32'(i);
    end
    $readmemh("tb/rv_stimulus.txt", stim_mem);
    // Trap column is 0 or 1 on loaded lines only
    while (count < MAX_ENTRIES && stim_mem[count*FIELDS+1] <= 32'd1) begin
      count++;
    end
    num_entries = count;
  endtask

  task automatic drive_entry(int idx);
    @(posedge clk);
    #1;
    i_instr_valid = 1'b1;
    i_instr       = stim_mem[idx*FIELDS];
    accepted++;
  endtask

  task automatic drive_idle(int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      i_instr_valid = 1'b0;
      i_instr       = 32'h0;
    end
  endtask

  task automatic check_retire();
    int    idx;
    int    base;
    string tag;
    if (retired >= accepted) begin
      report_error("writeback pulse without an accepted instruction");
    end
    idx  = retired % num_entries;
    base = idx * FIELDS;
    tag  = $sformatf("entry %0d of pass %0d", idx, retired / num_entries);
    check_flag({tag, " trap"}, stim_mem[base+1][0], o_wb_trap);
    check_flag({tag, " we"}, stim_mem[base+2][0], o_wb_we);
    check_reg({tag, " rd"}, stim_mem[base+3][4:0], o_wb_rd);
    check_word({tag, " data"}, stim_mem[base+4], o_wb_data);
    retired++;
  endtask

  // Writeback outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!i_rst) begin
      if ($isunknown(o_wb_valid)) begin
        report_error("o_wb_valid is unknown after reset");
      end else if (o_wb_valid) begin
        check_retire();
      end
    end
  end

  initial begin
    int limit;
    wait (num_entries > 0);
    // Three cycles per entry plus reset, idle stretches and pipeline fill
    limit = RESET_CYCLES + LEAD_IDLE + DRAIN_IDLE + PASSES * num_entries * 3 + 20;
    repeat (limit) @(posedge clk);
    report_error($sformatf("run did not complete within %0d clock cycles", limit));
  end

  initial begin
    int gap;
    i_rst         = 1'b1;
    i_instr_valid = 1'b0;
    i_instr       = 32'h0;
    accepted      = 0;
    retired       = 0;
    num_entries   = 0;
    lcg_state     = 32'hf569_24af;
    load_stimulus();
    if (num_entries == 0) begin
      report_error("stimulus file holds no entries");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    i_rst = 1'b0;
    drive_idle(LEAD_IDLE);
    // Back to back on the first pass and with random bubbles on the second
    for (int pass = 0; pass < PASSES; pass++) begin
      for (int idx = 0; idx < num_entries; idx++) begin
        drive_entry(idx);
        if (pass > 0) begin
          lcg_state = lcg_next(lcg_state);
          gap       = int'((lcg_state >> 16) % 32'd3);
          drive_idle(gap);
        end
      end
    end
    drive_idle(1);
    wait (retired == accepted);
    // Quiet stretch catches stray pulses
    drive_idle(DRAIN_IDLE);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* verilog/rv_pipeline.sv */
module rv_pipeline (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_instr_valid,
  input  logic [31:0]       i_instr,
  output logic              o_wb_valid,
  output logic              o_wb_trap,
  output logic              o_wb_we,
  output rv_pkg::reg_addr_t o_wb_rd,
  output rv_pkg::word_t     o_wb_data
);

  // IF/ID register and decode outputs
  logic              id_valid;
  logic [31:0]       id_instr;
  rv_pkg::reg_addr_t id_rs1;
  rv_pkg::reg_addr_t id_rs2;
  rv_pkg::reg_addr_t id_rd;
  rv_pkg::word_t     id_imm;
  logic              id_use_imm;
  rv_pkg::alu_op_e   id_alu_op;
  logic              id_reg_write;
  logic              id_trap;
  rv_pkg::word_t     id_rs1_data;
  rv_pkg::word_t     id_rs2_data;

  // ID/EX register
  logic              ex_valid;
  rv_pkg::reg_addr_t ex_rs1;
  rv_pkg::reg_addr_t ex_rs2;
  rv_pkg::reg_addr_t ex_rd;
  rv_pkg::word_t     ex_rs1_data;
  rv_pkg::word_t     ex_rs2_data;
  rv_pkg::word_t     ex_imm;
  logic              ex_use_imm;
  rv_pkg::alu_op_e   ex_alu_op;
  logic              ex_reg_write;
  logic              ex_trap;
  rv_pkg::word_t     ex_result;

  // EX/MEM register
  logic              mem_valid;
  rv_pkg::reg_addr_t mem_rd;
  logic              mem_reg_write;
  logic              mem_trap;
  rv_pkg::word_t     mem_result;
  logic              mem_we;

  // MEM/WB register
  logic              wb_valid;
  rv_pkg::reg_addr_t wb_rd;
  logic              wb_reg_write;
  logic              wb_trap;
  rv_pkg::word_t     wb_result;
  logic              wb_we;

  // Stage valid bits
  always_ff @(posedge clk) begin
    if (i_rst) begin
      id_valid  <= 1'b0;
      ex_valid  <= 1'b0;
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      id_valid  <= i_instr_valid;
      ex_valid  <= id_valid;
      mem_valid <= ex_valid;
      wb_valid  <= mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    id_instr      <= i_instr;
    ex_rs1        <= id_rs1;
    ex_rs2        <= id_rs2;
    ex_rd         <= id_rd;
    ex_rs1_data   <= id_rs1_data;
    ex_rs2_data   <= id_rs2_data;
    ex_imm        <= id_imm;
    ex_use_imm    <= id_use_imm;
    ex_alu_op     <= id_alu_op;
    ex_reg_write  <= id_reg_write;
    ex_trap       <= id_trap;
    mem_rd        <= ex_rd;
    mem_reg_write <= ex_reg_write;
    mem_trap      <= ex_trap;
    // Trapped instructions retire with zero data
    mem_result    <= ex_trap ? '0 : ex_result;
    wb_rd         <= mem_rd;
    wb_reg_write  <= mem_reg_write;
    wb_trap       <= mem_trap;
    wb_result     <= mem_result;
  end

  assign mem_we = mem_valid & mem_reg_write;
  assign wb_we  = wb_valid & wb_reg_write;

  rv_decoder u_decoder (
    .i_instr     (id_instr),
    .o_rs1       (id_rs1),
    .o_rs2       (id_rs2),
    .o_rd        (id_rd),
    .o_imm       (id_imm),
    .o_use_imm   (id_use_imm),
    .o_alu_op    (id_alu_op),
    .o_reg_write (id_reg_write),
    .o_trap      (id_trap)
  );

  rv_regfile u_regfile (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_we      (wb_we),
    .i_waddr   (wb_rd),
    .i_wdata   (wb_result),
    .i_raddr_a (id_rs1),
    .i_raddr_b (id_rs2),
    .o_rdata_a (id_rs1_data),
    .o_rdata_b (id_rs2_data)
  );

  rv_execute u_execute (
    .i_rs1        (ex_rs1),
    .i_rs2        (ex_rs2),
    .i_rs1_data   (ex_rs1_data),
    .i_rs2_data   (ex_rs2_data),
    .i_imm        (ex_imm),
    .i_use_imm    (ex_use_imm),
    .i_alu_op     (ex_alu_op),
    .i_mem_rd     (mem_rd),
    .i_mem_we     (mem_we),
    .i_mem_result (mem_result),
    .i_wb_rd      (wb_rd),
    .i_wb_we      (wb_we),
    .i_wb_result  (wb_result),
    .o_result     (ex_result)
  );

  assign o_wb_valid = wb_valid;
  assign o_wb_trap  = wb_valid & wb_trap;
  assign o_wb_we    = wb_we;
  assign o_wb_rd    = wb_rd;
  assign o_wb_data  = wb_result;

  a_wb_valid_known: assert property (@(posedge clk) disable iff (i_rst) !$isunknown(o_wb_valid));

endmodule

/* verilog/rv_regfile.sv */
module rv_regfile (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_we,
  input  rv_pkg::reg_addr_t i_waddr,
  input  rv_pkg::word_t     i_wdata,
  input  rv_pkg::reg_addr_t i_raddr_a,
  input  rv_pkg::reg_addr_t i_raddr_b,
  output rv_pkg::word_t     o_rdata_a,
  output rv_pkg::word_t     o_rdata_b
);

  // x0 has no storage
  rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  function automatic rv_pkg::word_t read_port(rv_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (i_we && i_waddr == addr) begin
      return i_wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    o_rdata_a = read_port(i_raddr_a);
    o_rdata_b = read_port(i_raddr_b);
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (i_rst) i_we |-> i_waddr != '0);
  a_wdata_known: assert property (@(posedge clk) disable iff (i_rst) i_we |-> !$isunknown(i_wdata));

endmodule

/* verilog/rv_decoder.sv */
module rv_decoder (
  input  logic [31:0]       i_instr,
  output rv_pkg::reg_addr_t o_rs1,
  output rv_pkg::reg_addr_t o_rs2,
  output rv_pkg::reg_addr_t o_rd,
  output rv_pkg::word_t     o_imm,
  output logic              o_use_imm,
  output rv_pkg::alu_op_e   o_alu_op,
  output logic              o_reg_write,
  output logic              o_trap
);

  logic [6:0]      opcode;
  logic [6:0]      funct7;
  rv_pkg::funct3_e funct3;
  logic            f7_zero;
  logic            f7_alt;
  logic            legal;

  assign opcode  = i_instr[6:0];
  assign funct7  = i_instr[31:25];
  assign funct3  = rv_pkg::funct3_e'(i_instr[14:12]);
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // Shared funct3 mapping for op_imm and op_reg
  function automatic rv_pkg::alu_op_e base_op(rv_pkg::funct3_e f3);
    case (f3)
      rv_pkg::f3_sll:  return rv_pkg::alu_sll;
      rv_pkg::f3_slt:  return rv_pkg::alu_slt;
      rv_pkg::f3_sltu: return rv_pkg::alu_sltu;
      rv_pkg::f3_xor:  return rv_pkg::alu_xor;
      rv_pkg::f3_sr:   return rv_pkg::alu_srl;
      rv_pkg::f3_or:   return rv_pkg::alu_or;
      rv_pkg::f3_and:  return rv_pkg::alu_and;
      default:         return rv_pkg::alu_add;
    endcase
  endfunction

  always_comb begin
    o_rs1     = i_instr[19:15];
    o_rs2     = i_instr[24:20];
    o_rd      = i_instr[11:7];
    o_imm     = {{20{i_instr[31]}}, i_instr[31:20]};
    o_use_imm = 1'b0;
    o_alu_op  = rv_pkg::alu_add;
    legal     = 1'b1;
    case (opcode)
      rv_pkg::op_lui: begin
        // x0 + upper immediate through the adder
        o_rs1     = '0;
        o_imm     = {i_instr[31:12], 12'b0};
        o_use_imm = 1'b1;
      end
      rv_pkg::op_imm: begin
        o_use_imm = 1'b1;
        o_alu_op  = base_op(funct3);
        if (funct3 == rv_pkg::f3_sll) begin
          legal = f7_zero;
        end else if (funct3 == rv_pkg::f3_sr) begin
          legal = f7_zero | f7_alt;
          if (f7_alt) begin
            o_alu_op = rv_pkg::alu_sra;
          end
        end
      end
      rv_pkg::op_reg: begin
        o_alu_op = base_op(funct3);
        legal    = f7_zero;
        // Only add and shift-right have an alternate form
        if (f7_alt && funct3 == rv_pkg::f3_add) begin
          legal    = 1'b1;
          o_alu_op = rv_pkg::alu_sub;
        end else if (f7_alt && funct3 == rv_pkg::f3_sr) begin
          legal    = 1'b1;
          o_alu_op = rv_pkg::alu_sra;
        end
      end
      default: legal = 1'b0;
    endcase
    o_trap      = !legal;
    o_reg_write = legal && (o_rd != '0);
  end

endmodule

/* verilog/rv_execute.sv */
module rv_execute (
  input  rv_pkg::reg_addr_t i_rs1,
  input  rv_pkg::reg_addr_t i_rs2,
  input  rv_pkg::word_t     i_rs1_data,
  input  rv_pkg::word_t     i_rs2_data,
  input  rv_pkg::word_t     i_imm,
  input  logic              i_use_imm,
  input  rv_pkg::alu_op_e   i_alu_op,
  input  rv_pkg::reg_addr_t i_mem_rd,
  input  logic              i_mem_we,
  input  rv_pkg::word_t     i_mem_result,
  input  rv_pkg::reg_addr_t i_wb_rd,
  input  logic              i_wb_we,
  input  rv_pkg::word_t     i_wb_result,
  output rv_pkg::word_t     o_result
);

  rv_pkg::word_t op_a;
  rv_pkg::word_t fwd_b;
  rv_pkg::word_t op_b;

  // Newest producer wins, write enables already exclude x0
  function automatic rv_pkg::word_t forward(rv_pkg::reg_addr_t rs, rv_pkg::word_t rf_data);
    if (i_mem_we && rs == i_mem_rd) begin
      return i_mem_result;
    end else if (i_wb_we && rs == i_wb_rd) begin
      return i_wb_result;
    end
    return rf_data;
  endfunction

  always_comb begin
    op_a  = forward(i_rs1, i_rs1_data);
    fwd_b = forward(i_rs2, i_rs2_data);
    op_b  = i_use_imm ? i_imm : fwd_b;
  end

  rv_alu u_alu (
    .i_op     (i_alu_op),
    .i_a      (op_a),
    .i_b      (op_b),
    .o_result (o_result)
  );

endmodule

/* verilog/rv_alu.sv */
module rv_alu (
  input  rv_pkg::alu_op_e i_op,
  input  rv_pkg::word_t   i_a,
  input  rv_pkg::word_t   i_b,
  output rv_pkg::word_t   o_result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = i_b[4:0];
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      rv_pkg::alu_add:  o_result = i_a + i_b;
      rv_pkg::alu_sub:  o_result = i_a - i_b;
      rv_pkg::alu_sll:  o_result = i_a << shamt;
      // Comparisons produce 0 or 1
      rv_pkg::alu_slt:  o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
      rv_pkg::alu_sltu: o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
      rv_pkg::alu_xor:  o_result = i_a ^ i_b;
      rv_pkg::alu_srl:  o_result = i_a >> shamt;
      rv_pkg::alu_sra:  o_result = rv_pkg::word_t'($signed(i_a) >>> shamt);
      rv_pkg::alu_or:   o_result = i_a | i_b;
      rv_pkg::alu_and:  o_result = i_a & i_b;
      default:          o_result = '0;
    endcase
  end

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

  // Fixed by the RV32I base ISA
  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  // Major opcodes handled by this datapath
  typedef enum logic [6:0] {
    op_lui = 7'b0110111,
    op_imm = 7'b0010011,
    op_reg = 7'b0110011
  } opcode_e;

  // funct3 encodings of the integer ALU group
  typedef enum logic [2:0] {
    f3_add  = 3'b000,
    f3_sll  = 3'b001,
    f3_slt  = 3'b010,
    f3_sltu = 3'b011,
    f3_xor  = 3'b100,
    f3_sr   = 3'b101,
    f3_or   = 3'b110,
    f3_and  = 3'b111
  } funct3_e;

  // Operation carried from decode to the ALU
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

endpackage
